//--- design/tomasulo_pkg.sv
package tomasulo_pkg;

    // tag field width in the shared structs
    // covers buffers up to 16 entries, modules use the low clog2 bits
    localparam int ROB_TAG_W = 4;

    // operations accepted from issue
    typedef enum logic [2:0] {
        OP_ADD    = 3'd0,
        OP_SUB    = 3'd1,
        OP_AND    = 3'd2,
        OP_OR     = 3'd3,
        OP_LD     = 3'd4,
        OP_ST     = 3'd5,
        OP_BRANCH = 3'd6
    } opcode_t;

    // commit sequencer states
    typedef enum logic [1:0] {
        IDLE     = 2'd0,
        MEM_WAIT = 2'd1,
        SQUASH   = 2'd2
    } flush_state_t;

    // decoded instruction from the issue stage
    typedef struct packed {
        opcode_t     op;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [15:0] imm;
        logic        pred_taken;
    } dispatch_t;

    // dispatch to execution unit
    typedef struct packed {
        logic                 valid;
        opcode_t              op;
        logic [ROB_TAG_W-1:0] tag;
        logic [31:0]          a;
        logic [31:0]          b;
        logic [15:0]          imm;
    } exec_req_t;

    // common data bus beat
    typedef struct packed {
        logic                 valid;
        logic [ROB_TAG_W-1:0] tag;
        logic [31:0]          value;
        logic                 taken;
    } cdb_t;

    // architectural retirement
    typedef struct packed {
        logic        valid;
        logic [4:0]  rd;
        logic [31:0] value;
        logic        we;
    } commit_t;

    // strobe held until mem_resp
    typedef struct packed {
        logic        read;
        logic        write;
        logic [31:0] addr;
        logic [31:0] wdata;
    } mem_req_t;

endpackage

//--- design/rob.sv
`timescale 1ns/100ps

module rob
    import tomasulo_pkg::*;
#(
    parameter int ROB_DEPTH = 8
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        dispatch_valid,
    input  dispatch_t   dispatch,
    output logic        dispatch_ready,
    output exec_req_t   exec_req,
    input  cdb_t        cdb,
    output commit_t     commit,
    output logic [4:0]  st_src,
    input  logic [31:0] st_data,
    output mem_req_t    mem_req,
    input  logic        mem_resp,
    input  logic [31:0] mem_rdata,
    output logic        redirect,
    output logic [31:0] redirect_pc,
    output logic        rob_full
);

    localparam int IDX_W = $clog2(ROB_DEPTH);
    localparam int CNT_W = IDX_W + 1;

    // per-entry payload
    opcode_t     op_arr    [ROB_DEPTH];
    logic [4:0]  rd_arr    [ROB_DEPTH];
    logic [31:0] val_arr   [ROB_DEPTH];
    logic        taken_arr [ROB_DEPTH];
    logic        pred_arr  [ROB_DEPTH];

    // per-entry control
    logic [ROB_DEPTH-1:0] alloc;
    logic [ROB_DEPTH-1:0] done;

    logic [IDX_W-1:0] head, tail, cdb_idx;
    logic [CNT_W-1:0] count;
    flush_state_t     state, next_state;
    logic             started;
    logic             push, pop;
    logic             hazard, mem_busy, is_mem_op;

    // ops that retire into the register file
    function automatic logic writes_reg(opcode_t op);
        return (op == OP_ADD) || (op == OP_SUB) || (op == OP_AND) ||
               (op == OP_OR) || (op == OP_LD);
    endfunction

    assign cdb_idx   = cdb.tag[IDX_W-1:0];
    assign rob_full  = (count == CNT_W'(ROB_DEPTH));
    assign is_mem_op = (dispatch.op == OP_LD) || (dispatch.op == OP_ST);

    // true-dependence interlock and single memory op in flight
    always_comb begin
        hazard   = 1'b0;
        mem_busy = 1'b0;
        for (int i = 0; i < ROB_DEPTH; i++) begin
            if (alloc[i]) begin
                if (writes_reg(op_arr[i]) && (rd_arr[i] != 5'd0) &&
                    ((rd_arr[i] == dispatch.rs1) || (rd_arr[i] == dispatch.rs2))) begin
                    hazard = 1'b1;
                end
                if ((op_arr[i] == OP_LD) || (op_arr[i] == OP_ST)) begin
                    mem_busy = 1'b1;
                end
            end
        end
    end

    assign dispatch_ready = started && !rob_full && (state != SQUASH) && !redirect &&
                            !hazard && !(mem_busy && is_mem_op);
    assign push = dispatch_valid && dispatch_ready;

    // operand fields filled from the register file at the top level
    assign exec_req = '{valid: push, op: dispatch.op, tag: ROB_TAG_W'(tail),
                        a: 32'd0, b: 32'd0, imm: dispatch.imm};

    // store data register kept in the rd slot of a store entry
    assign st_src = rd_arr[head];

    // commit sequencer, head entry only
    always_comb begin
        next_state  = state;
        commit      = '0;
        mem_req     = '0;
        redirect    = 1'b0;
        redirect_pc = 32'd0;
        pop         = 1'b0;
        case (state)
            IDLE: begin
                if (alloc[head] && done[head]) begin
                    commit.rd    = rd_arr[head];
                    commit.value = val_arr[head];
                    case (op_arr[head])
                        // memory ops wait for the port
                        OP_LD, OP_ST: next_state = MEM_WAIT;
                        OP_BRANCH: begin
                            commit.valid = 1'b1;
                            pop          = 1'b1;
                            // wrong guess, not-taken path restarts at 0
                            if (taken_arr[head] != pred_arr[head]) begin
                                redirect    = 1'b1;
                                redirect_pc = taken_arr[head] ? val_arr[head] : 32'd0;
                                next_state  = SQUASH;
                            end
                        end
                        default: begin
                            commit.valid = 1'b1;
                            commit.we    = 1'b1;
                            pop          = 1'b1;
                        end
                    endcase
                end
            end
            MEM_WAIT: begin
                // address computed by the exec unit
                mem_req.read  = (op_arr[head] == OP_LD);
                mem_req.write = (op_arr[head] == OP_ST);
                mem_req.addr  = val_arr[head];
                mem_req.wdata = (op_arr[head] == OP_ST) ? st_data : 32'd0;
                if (mem_resp) begin
                    commit.valid = 1'b1;
                    commit.rd    = rd_arr[head];
                    commit.we    = (op_arr[head] == OP_LD);
                    // store retires with the data it wrote
                    commit.value = (op_arr[head] == OP_LD) ? mem_rdata : st_data;
                    pop          = 1'b1;
                    next_state   = IDLE;
                end
            end
            default: next_state = IDLE;
        endcase
    end

    // pointers, occupancy and entry status
    always_ff @(posedge clk) begin
        if (rst) begin
            head    <= '0;
            tail    <= '0;
            count   <= '0;
            alloc   <= '0;
            done    <= '0;
            state   <= IDLE;
            started <= 1'b0;
        end else begin
            started <= 1'b1;
            state   <= next_state;
            count   <= count + CNT_W'(push) - CNT_W'(pop);
            if (cdb.valid && alloc[cdb_idx]) begin
                done[cdb_idx] <= 1'b1;
            end
            if (push) begin
                alloc[tail] <= 1'b1;
                done[tail]  <= 1'b0;
                tail        <= tail + 1'b1;
            end
            if (pop) begin
                alloc[head] <= 1'b0;
                done[head]  <= 1'b0;
                head        <= head + 1'b1;
            end
            // head is past the branch, so every live entry is younger
            if (state == SQUASH) begin
                alloc <= '0;
                done  <= '0;
                tail  <= head;
                count <= '0;
            end
        end
    end

    // entry payload
    always_ff @(posedge clk) begin
        if (push) begin
            op_arr[tail]   <= dispatch.op;
            rd_arr[tail]   <= (dispatch.op == OP_ST) ? dispatch.rs2 : dispatch.rd;
            pred_arr[tail] <= dispatch.pred_taken;
        end
        if (cdb.valid && alloc[cdb_idx]) begin
            val_arr[cdb_idx]   <= cdb.value;
            taken_arr[cdb_idx] <= cdb.taken;
        end
    end

endmodule

//--- design/regfile.sv
`timescale 1ns/100ps

module regfile
    import tomasulo_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic [4:0]  rs1,
    input  logic [4:0]  rs2,
    input  logic [4:0]  st_src,
    output logic [31:0] rs1_data,
    output logic [31:0] rs2_data,
    output logic [31:0] st_data,
    input  commit_t     commit
);

    logic [31:0] regs [32];

    // architectural state, written only at retirement
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= 32'd0;
            end
        end else if (commit.valid && commit.we && (commit.rd != 5'd0)) begin
            regs[commit.rd] <= commit.value;
        end
    end

    // dispatch operand ports
    // x0 always reads zero
    assign rs1_data = (rs1 == 5'd0) ? 32'd0 : regs[rs1];
    assign rs2_data = (rs2 == 5'd0) ? 32'd0 : regs[rs2];

    // store data for the head entry
    assign st_data  = (st_src == 5'd0) ? 32'd0 : regs[st_src];

endmodule

//--- design/int_exec_unit.sv
`timescale 1ns/100ps

module int_exec_unit
    import tomasulo_pkg::*;
#(
    parameter int ROB_DEPTH = 8
) (
    input  logic      clk,
    input  logic      rst,
    input  exec_req_t exec_req,
    output cdb_t      cdb
);

    localparam int IDX_W = $clog2(ROB_DEPTH);

    logic [31:0] result;
    logic        br_taken;
    logic [31:0] imm_sext;

    // stage one registers
    logic             s1_valid;
    logic [IDX_W-1:0] s1_tag;
    logic [31:0]      s1_result;
    logic             s1_taken;

    assign imm_sext = {{16{exec_req.imm[15]}}, exec_req.imm};

    // op select
    always_comb begin
        result   = 32'd0;
        br_taken = 1'b0;
        case (exec_req.op)
            OP_ADD: result = exec_req.a + exec_req.b;
            OP_SUB: result = exec_req.a - exec_req.b;
            OP_AND: result = exec_req.a & exec_req.b;
            OP_OR:  result = exec_req.a | exec_req.b;
            // effective address
            OP_LD, OP_ST: result = exec_req.a + imm_sext;
            OP_BRANCH: begin
                // absolute target, beq compare
                result   = {16'd0, exec_req.imm};
                br_taken = (exec_req.a == exec_req.b);
            end
            default: result = 32'd0;
        endcase
    end

    // stage one
    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= exec_req.valid;
        end
        s1_tag    <= exec_req.tag[IDX_W-1:0];
        s1_result <= result;
        s1_taken  <= br_taken;
    end

    // stage two, result onto the bus
    always_ff @(posedge clk) begin
        if (rst) begin
            cdb.valid <= 1'b0;
        end else begin
            cdb.valid <= s1_valid;
        end
        cdb.tag   <= ROB_TAG_W'(s1_tag);
        cdb.value <= s1_result;
        cdb.taken <= s1_taken;
    end

endmodule

//--- design/ooo_backend.sv
`timescale 1ns/100ps

module ooo_backend
    import tomasulo_pkg::*;
#(
    parameter int ROB_DEPTH = 8
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        dispatch_valid,
    input  dispatch_t   dispatch,
    output logic        dispatch_ready,
    output commit_t     commit,
    output mem_req_t    mem_req,
    input  logic        mem_resp,
    input  logic [31:0] mem_rdata,
    output logic        redirect,
    output logic [31:0] redirect_pc,
    output logic        rob_full
);

    exec_req_t   rob_exec;
    exec_req_t   exec_req;
    cdb_t        cdb;
    logic [4:0]  st_src;
    logic [31:0] st_data;
    logic [31:0] rs1_data;
    logic [31:0] rs2_data;

    // operands join the request in the dispatch cycle
    assign exec_req = '{valid: rob_exec.valid, op: rob_exec.op, tag: rob_exec.tag,
                        a: rs1_data, b: rs2_data, imm: rob_exec.imm};

    rob #(.ROB_DEPTH(ROB_DEPTH)) rob_i (
        .clk            (clk),
        .rst            (rst),
        .dispatch_valid (dispatch_valid),
        .dispatch       (dispatch),
        .dispatch_ready (dispatch_ready),
        .exec_req       (rob_exec),
        .cdb            (cdb),
        .commit         (commit),
        .st_src         (st_src),
        .st_data        (st_data),
        .mem_req        (mem_req),
        .mem_resp       (mem_resp),
        .mem_rdata      (mem_rdata),
        .redirect       (redirect),
        .redirect_pc    (redirect_pc),
        .rob_full       (rob_full)
    );

    // source regs straight from the offered instruction
    regfile regfile_i (
        .clk      (clk),
        .rst      (rst),
        .rs1      (dispatch.rs1),
        .rs2      (dispatch.rs2),
        .st_src   (st_src),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .st_data  (st_data),
        .commit   (commit)
    );

    int_exec_unit #(.ROB_DEPTH(ROB_DEPTH)) int_exec_unit_i (
        .clk      (clk),
        .rst      (rst),
        .exec_req (exec_req),
        .cdb      (cdb)
    );

endmodule

//--- tests/ooo_backend_asserts.sv
`timescale 1ns/100ps

module ooo_backend_asserts
    import tomasulo_pkg::*;
(
    input logic     clk,
    input logic     rst,
    input logic     dispatch_valid,
    input logic     dispatch_ready,
    input logic     rob_full,
    input mem_req_t mem_req,
    input logic     mem_resp,
    input logic     redirect,
    input commit_t  commit
);

    // failure tally, summed into the testbench error count
    int fail_count = 0;

    // nothing allocated into a full buffer
    no_push_when_full: assert property (@(posedge clk) disable iff (rst)
        rob_full |-> !(dispatch_valid && dispatch_ready))
        else begin
            fail_count++;
            $error("dispatch transfer accepted while the buffer was full");
        end

    // one memory direction at a time
    read_write_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(mem_req.read && mem_req.write))
        else begin
            fail_count++;
            $error("memory read and write strobes high together");
        end

    // strobe, address and data held until the response
    mem_req_held: assert property (@(posedge clk) disable iff (rst)
        (mem_req.read || mem_req.write) && !mem_resp |=> $stable(mem_req))
        else begin
            fail_count++;
            $error("memory request changed before mem_resp");
        end

    // redirect is a single-cycle pulse
    redirect_pulse: assert property (@(posedge clk) disable iff (rst)
        redirect |=> !redirect)
        else begin
            fail_count++;
            $error("redirect high on two consecutive cycles");
        end

    // quiet commit port once reset has taken hold
    no_commit_in_reset: assert property (@(posedge clk)
        rst && $past(rst) |-> !commit.valid)
        else begin
            fail_count++;
            $error("commit valid while reset asserted");
        end

endmodule

bind rob ooo_backend_asserts asserts_i (
    .clk            (clk),
    .rst            (rst),
    .dispatch_valid (dispatch_valid),
    .dispatch_ready (dispatch_ready),
    .rob_full       (rob_full),
    .mem_req        (mem_req),
    .mem_resp       (mem_resp),
    .redirect       (redirect),
    .commit         (commit)
);

//--- tests/ooo_backend_tb.sv
`timescale 1ns/100ps

module ooo_backend_tb
    import tomasulo_pkg::*;
();

    localparam int CLK_PERIOD   = 10;
    localparam int RESET_CYCLES = 10;
    localparam int NUM_TESTS    = 6;
    localparam int ROB_DEPTH    = 8;

    logic        clk;
    logic        rst;
    logic        dispatch_valid;
    dispatch_t   dispatch;
    logic        dispatch_ready;
    commit_t     commit;
    mem_req_t    mem_req;
    logic        mem_resp = 1'b0;
    logic [31:0] mem_rdata = 32'd0;
    logic        redirect;
    logic [31:0] redirect_pc;
    logic        rob_full;

    // memory responder
    logic [31:0] resp_mem [64];
    logic        mem_hold = 1'b0;
    logic        mem_waiting = 1'b0;
    int          mem_delay = 0;
    integer      seed = 32'hc98b_6c91;

    // golden in-order model
    logic [31:0] model_regs [32];
    logic [31:0] model_mem [64];
    logic [31:0] exp_branch_pc = 32'd0;
    commit_t     exp_q [$];
    commit_t     exp_c;

    int          errors = 0;
    int          commits_checked = 0;
    int          redirect_count = 0;
    logic [31:0] seen_pc = 32'd0;
    int          last_stalls = 0;
    int          base_err = 0;
    int          base_redir = 0;

    ooo_backend #(.ROB_DEPTH(ROB_DEPTH)) dut_i (
        .clk            (clk),
        .rst            (rst),
        .dispatch_valid (dispatch_valid),
        .dispatch       (dispatch),
        .dispatch_ready (dispatch_ready),
        .commit         (commit),
        .mem_req        (mem_req),
        .mem_resp       (mem_resp),
        .mem_rdata      (mem_rdata),
        .redirect       (redirect),
        .redirect_pc    (redirect_pc),
        .rob_full       (rob_full)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // 200 cycles per test on top of reset
    initial begin
        #((RESET_CYCLES + 200 * NUM_TESTS) * CLK_PERIOD);
        $display("timeout: tests did not finish in %0d cycles", RESET_CYCLES + 200 * NUM_TESTS);
        $display("sim failed");
        $finish;
    end

    function automatic logic [31:0] fill_word(input int idx);
        return 32'h1357_0000 ^ (32'(idx) * 32'h0104_0811);
    endfunction

    function automatic dispatch_t make_instr(input opcode_t op, input logic [4:0] rd,
            input logic [4:0] rs1, input logic [4:0] rs2, input logic [15:0] imm,
            input logic pred);
        dispatch_t d;
        d.op = op;
        d.rd = rd;
        d.rs1 = rs1;
        d.rs2 = rs2;
        d.imm = imm;
        d.pred_taken = pred;
        return d;
    endfunction

    // architectural effect of one instruction, queued as its expected commit
    function automatic void model_instr(input dispatch_t d);
        commit_t     e;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] addr;
        a = model_regs[d.rs1];
        b = model_regs[d.rs2];
        addr = a + {{16{d.imm[15]}}, d.imm};
        e = '0;
        e.valid = 1'b1;
        e.rd = d.rd;
        case (d.op)
            OP_ADD: e.value = a + b;
            OP_SUB: e.value = a - b;
            OP_AND: e.value = a & b;
            OP_OR:  e.value = a | b;
            OP_LD:  e.value = model_mem[addr[7:2]];
            OP_ST: begin
                // store retires with its data, rd slot names the source
                e.rd = d.rs2;
                e.value = b;
                model_mem[addr[7:2]] = b;
            end
            default: begin
                e.value = {16'd0, d.imm};
                exp_branch_pc = (a == b) ? e.value : 32'd0;
            end
        endcase
        e.we = (d.op != OP_ST) && (d.op != OP_BRANCH);
        if (e.we && (d.rd != 5'd0)) begin
            model_regs[d.rd] = e.value;
        end
        exp_q.push_back(e);
    endfunction

    function automatic int total_errors();
        return errors + dut_i.rob_i.asserts_i.fail_count;
    endfunction

    // offer at the falling edge, ready sampled mid low phase
    task automatic issue(input dispatch_t d, input logic model);
        last_stalls = 0;
        if (model) begin
            model_instr(d);
        end
        dispatch = d;
        dispatch_valid = 1'b1;
        #2;
        while (!dispatch_ready) begin
            @(negedge clk);
            last_stalls++;
            #2;
        end
        @(negedge clk);
        dispatch_valid = 1'b0;
    endtask

    task automatic drain();
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        // squash and late bus beats settle
        repeat (3) @(negedge clk);
    endtask

    task automatic check_stalled();
        assert (last_stalls > 0) else begin
            errors++;
            $display("interlock failed: consumer accepted at %0t with producer in flight", $time);
        end
    endtask

    task automatic report_test(input int num, input string name);
        drain();
        $display("test %0d %s: %s", num, name, (total_errors() == base_err) ? "ok" : "errors found");
        base_err = total_errors();
    endtask

    task automatic run_mispredict(input dispatch_t br, input dispatch_t good);
        int target;
        target = redirect_count + 1;
        issue(br, 1'b1);
        // wrong path, already in the buffer when the branch resolves
        issue(make_instr(OP_ADD, 5'd25, 5'd1, 5'd2, 16'd0, 1'b0), 1'b0);
        issue(make_instr(OP_OR, 5'd26, 5'd3, 5'd4, 16'd0, 1'b0), 1'b0);
        while (redirect_count < target) begin
            @(negedge clk);
        end
        assert (seen_pc == exp_branch_pc) else begin
            errors++;
            $display("[ERROR] %0t: redirect_pc expected %h, got %h", $time, exp_branch_pc, seen_pc);
        end
        issue(good, 1'b1);
        drain();
    endtask

    // responder, 0 to 3 cycle delay per held request
    always @(negedge clk) begin
        if (rst || mem_resp) begin
            mem_resp <= 1'b0;
        end else if ((mem_req.read || mem_req.write) && !mem_hold) begin
            if (!mem_waiting) begin
                mem_waiting = 1'b1;
                mem_delay = {$random(seed)} % 4;
            end
            if (mem_delay == 0) begin
                mem_waiting = 1'b0;
                mem_resp <= 1'b1;
                if (mem_req.write) begin
                    resp_mem[mem_req.addr[7:2]] = mem_req.wdata;
                end else begin
                    mem_rdata <= resp_mem[mem_req.addr[7:2]];
                end
            end else begin
                mem_delay = mem_delay - 1;
            end
        end
    end

    // scoreboard and redirect monitor
    always @(posedge clk) begin
        if (!rst && redirect) begin
            redirect_count++;
            seen_pc = redirect_pc;
        end
        if (!rst && commit.valid) begin
            commits_checked++;
            assert (exp_q.size() != 0) else begin
                errors++;
                $display("[ERROR] %0t: unexpected commit rd=%0d value=%h", $time,
                         commit.rd, commit.value);
            end
            if (exp_q.size() != 0) begin
                exp_c = exp_q.pop_front();
                assert ((commit.rd == exp_c.rd) && (commit.value == exp_c.value) &&
                        (commit.we == exp_c.we)) else begin
                    errors++;
                    $display("[ERROR] %0t: expected rd=%0d value=%h we=%b, got rd=%0d value=%h we=%b",
                             $time, exp_c.rd, exp_c.value, exp_c.we,
                             commit.rd, commit.value, commit.we);
                end
            end
        end
    end

    initial begin
        dispatch_t held;
        rst = 1'b1;
        dispatch_valid = 1'b0;
        dispatch = '0;
        for (int i = 0; i < 64; i++) begin
            resp_mem[i] = fill_word(i);
            model_mem[i] = fill_word(i);
        end
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = 32'd0;
        end
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;

        // seed x1..x4 from memory, then independent alu work
        for (int i = 1; i <= 4; i++) begin
            issue(make_instr(OP_LD, 5'(i), 5'd0, 5'd0, 16'(4 * (i - 1)), 1'b0), 1'b1);
        end
        issue(make_instr(OP_ADD, 5'd10, 5'd1, 5'd2, 16'd0, 1'b0), 1'b1);
        issue(make_instr(OP_SUB, 5'd11, 5'd3, 5'd4, 16'd0, 1'b0), 1'b1);
        issue(make_instr(OP_AND, 5'd12, 5'd1, 5'd3, 16'd0, 1'b0), 1'b1);
        issue(make_instr(OP_OR, 5'd13, 5'd2, 5'd4, 16'd0, 1'b0), 1'b1);
        issue(make_instr(OP_SUB, 5'd14, 5'd2, 5'd1, 16'd0, 1'b0), 1'b1);
        report_test(1, "independent alu");

        // chain through x5..x8
        issue(make_instr(OP_ADD, 5'd5, 5'd1, 5'd2, 16'd0, 1'b0), 1'b1);
        issue(make_instr(OP_SUB, 5'd6, 5'd5, 5'd3, 16'd0, 1'b0), 1'b1);
        check_stalled();
        issue(make_instr(OP_OR, 5'd7, 5'd6, 5'd5, 16'd0, 1'b0), 1'b1);
        check_stalled();
        issue(make_instr(OP_AND, 5'd8, 5'd7, 5'd1, 16'd0, 1'b0), 1'b1);
        check_stalled();
        report_test(2, "dependence interlock");

        // store then load back, also a negative offset
        issue(make_instr(OP_ST, 5'd0, 5'd0, 5'd5, 16'h0020, 1'b0), 1'b1);
        issue(make_instr(OP_LD, 5'd9, 5'd0, 5'd0, 16'h0020, 1'b0), 1'b1);
        issue(make_instr(OP_ADD, 5'd15, 5'd9, 5'd1, 16'd0, 1'b0), 1'b1);
        issue(make_instr(OP_ST, 5'd0, 5'd0, 5'd6, 16'hfff0, 1'b0), 1'b1);
        issue(make_instr(OP_LD, 5'd11, 5'd0, 5'd0, 16'hfff0, 1'b0), 1'b1);
        issue(make_instr(OP_ADD, 5'd12, 5'd1, 5'd2, 16'd0, 1'b0), 1'b1);
        report_test(3, "load store sequencing");

        // stalled load at head, alu ops fill the buffer behind it
        mem_hold = 1'b1;
        issue(make_instr(OP_LD, 5'd16, 5'd0, 5'd0, 16'h0010, 1'b0), 1'b1);
        for (int i = 0; i < ROB_DEPTH - 1; i++) begin
            issue(make_instr(OP_ADD, 5'(17 + i), 5'd1, 5'd2, 16'd0, 1'b0), 1'b1);
        end
        held = make_instr(OP_OR, 5'd24, 5'd1, 5'd2, 16'd0, 1'b0);
        dispatch = held;
        dispatch_valid = 1'b1;
        repeat (4) begin
            #2;
            assert (rob_full && !dispatch_ready) else begin
                errors++;
                $display("back-pressure failed: dispatch open or buffer not full at %0t", $time);
            end
            @(negedge clk);
        end
        mem_hold = 1'b0;
        issue(held, 1'b1);
        report_test(4, "back-pressure");

        // taken branch guessed not taken, then not taken guessed taken
        base_redir = redirect_count;
        run_mispredict(make_instr(OP_BRANCH, 5'd0, 5'd1, 5'd1, 16'h0140, 1'b0),
                       make_instr(OP_OR, 5'd27, 5'd1, 5'd3, 16'd0, 1'b0));
        run_mispredict(make_instr(OP_BRANCH, 5'd0, 5'd1, 5'd2, 16'h0180, 1'b1),
                       make_instr(OP_SUB, 5'd28, 5'd4, 5'd2, 16'd0, 1'b0));
        assert (redirect_count == base_redir + 2) else begin
            errors++;
            $display("redirect pulse count wrong: %0d pulses for two mispredicts",
                     redirect_count - base_redir);
        end
        report_test(5, "branch mispredict");

        // both guesses right, no redirect expected
        base_redir = redirect_count;
        issue(make_instr(OP_BRANCH, 5'd0, 5'd1, 5'd2, 16'h0100, 1'b0), 1'b1);
        issue(make_instr(OP_ADD, 5'd29, 5'd1, 5'd2, 16'd0, 1'b0), 1'b1);
        issue(make_instr(OP_BRANCH, 5'd0, 5'd3, 5'd3, 16'h0200, 1'b1), 1'b1);
        issue(make_instr(OP_OR, 5'd30, 5'd29, 5'd4, 16'd0, 1'b0), 1'b1);
        drain();
        assert (redirect_count == base_redir) else begin
            errors++;
            $display("redirect raised for a correctly predicted branch");
        end
        report_test(6, "correct prediction");

        $display("tests run: %0d, commits checked: %0d, errors: %0d",
                 NUM_TESTS, commits_checked, total_errors());
        if (total_errors() == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- list.f
design/tomasulo_pkg.sv
design/rob.sv
design/regfile.sv
design/int_exec_unit.sv
design/ooo_backend.sv
tests/ooo_backend_asserts.sv
tests/ooo_backend_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the backend testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal -f list.f \
    --top-module ooo_backend_tb -o ooo_backend_sim \
    && ./obj_dir/ooo_backend_sim | tee sim.log \
    || { echo "build or run error"; exit 1; }

grep -qx "sim passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
